// File: verilog.f
+incdir+rtl
rtl/stateManagerPkg.sv
rtl/commandDecode.sv
rtl/operandReadPlanner.sv
rtl/writebackPlanner.sv
rtl/stepSequencer.sv
rtl/stateManager.sv
verif/stateManagerTb.sv

// File: Makefile
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module stateManagerTb \
		-Mdir $(OBJ_DIR) -o simv

run: compile
	./$(OBJ_DIR)/simv

clean:
	rm -rf $(OBJ_DIR)

// File: verif/stateManagerTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "stateManager_consts.svh"

module stateManagerTb;
  import stateManagerPkg::*;

  logic                      next_state;
  logic                      rst;
  logic [`SM_CMD_WIDTH-1:0]  command;
  logic [`SM_DATA_WIDTH-1:0] cond;
  logic                      chanWaitNextTime;
  logic                      isCndRead;
  logic                      isS1Read;
  logic                      isS0Read;
  smStateT                   state;
  logic                      nextStateDn;
  logic                      isIpSaveAllowed;
  logic                      isDSaveAllowed;
  logic                      isDSavePtrAllowed;
  logic                      isCndSaveAllowed;
  logic                      isS1SaveAllowed;
  logic                      isS0SaveAllowed;

  // reference model view of the command
  regNumT   nS1, nS0, nD, nC;
  regFlagsT fS1, fS0, fD, fC;
  logic     pS1, pS0, pD, pC;
  logic     mCondMet, mIp, mD, mDP, mC, mS1, mS0;
  // model step latches
  logic     mCondDone, mIpWritten, mChanOp;
  logic [31:0] lfsrState;
  // states seen in the last instruction
  logic [31:0] visited;
  smStateT     trace[$];

  stateManager stateManager_i (
    .next_state, .rst, .command, .cond, .chanWaitNextTime,
    .isCndRead, .isS1Read, .isS0Read,
    .state, .nextStateDn,
    .isIpSaveAllowed, .isDSaveAllowed, .isDSavePtrAllowed,
    .isCndSaveAllowed, .isS1SaveAllowed, .isS0SaveAllowed
  );

  initial begin
    next_state = 1'b0;
    forever #20 next_state = ~next_state;
  end

  task automatic stopRun();
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic compareState(string name, smStateT exp, smStateT act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %s, actual %s", name, exp.name(), act.name());
      stopRun();
    end
  endtask

  task automatic compareFlag(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %0b, actual %0b", name, exp, act);
      stopRun();
    end
  endtask

  // galois form, taps for x^32+x^22+x^2+x+1
  function automatic logic lfsrBit();
    logic b;
    b = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (b) begin
      lfsrState = lfsrState ^ 32'h80200003;
    end
    return b;
  endfunction

  function automatic logic [31:0] randomBits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsrBit()};
    end
    return r;
  endfunction

  // one flag bit set
  function automatic logic isWb(regFlagsT f);
    return (f == 2'b01) || (f == 2'b10);
  endfunction

  function automatic void decodeModel();
    nS1 = command[3:0];
    nS0 = command[7:4];
    nD  = command[11:8];
    nC  = command[15:12];
    pS1 = command[16];
    pS0 = command[17];
    pD  = command[18];
    pC  = command[19];
    fS1 = command[21:20];
    fS0 = command[23:22];
    fD  = command[25:24];
    fC  = command[27:26];
    mCondMet = (fC == 2'b11) || (cond != '0);
    mD  = (fD != 2'b11) && mCondMet;
    mDP = (fD == 2'b11) && pD && mCondMet;
    // save priority D, cond, src1, src0
    mC  = isWb(fC) && !(mD && nD == nC);
    mS1 = isWb(fS1) && !(mD && nD == nS1) && !(mC && nC == nS1);
    mS0 = isWb(fS0) && !(mD && nD == nS0) && !(mC && nC == nS0)
          && !(mS1 && nS1 == nS0);
    mIp = !((mD && nD == `SM_REG_IP) || (isWb(fC) && nC == `SM_REG_IP)
          || (isWb(fS1) && nS1 == `SM_REG_IP) || (isWb(fS0) && nS0 == `SM_REG_IP));
  endfunction

  // slot 0 cond, 1 src1, 2 src0, 3 dst
  function automatic smStateT readFrom(int slot);
    if (slot == 0 && fC != 2'b11 && !mCondDone) begin
      return (nC == `SM_REG_IP) ? fillCond : readCond;
    end
    if (slot <= 1 && fS1 != 2'b11) begin
      return (nS1 == `SM_REG_IP || (fC != 2'b11 && nS1 == nC && isCndRead))
             ? fillSrc1 : readSrc1;
    end
    if (slot <= 2 && fS0 != 2'b11) begin
      return (nS0 == `SM_REG_IP || (fC != 2'b11 && nS0 == nC && isCndRead)
             || (fS1 != 2'b11 && nS0 == nS1 && isS1Read)) ? fillSrc0 : readSrc0;
    end
    if (slot <= 3 && pD) begin
      return (nD == `SM_REG_IP || (fC != 2'b11 && nD == nC && isCndRead)
             || (fS1 != 2'b11 && nD == nS1 && isS1Read)
             || (fS0 != 2'b11 && nD == nS0 && isS0Read)) ? fillDstP : readDst;
    end
    return aluBegin;
  endfunction

  // slot 0 D, 1 cond, 2 src1, 3 src0
  function automatic smStateT writeFrom(int slot);
    if (slot == 0 && mD) begin
      return pD ? writeDstP : writeDst;
    end
    if (slot == 0 && mDP) begin
      return writeDstP;
    end
    if (slot <= 1 && mC) begin
      return writeCond;
    end
    if (slot <= 2 && mS1) begin
      return writeSrc1;
    end
    if (slot <= 3 && mS0) begin
      return writeSrc0;
    end
    return finishBegin;
  endfunction

  function automatic smStateT afterCond();
    return (mIp && !mCondMet && !mIpWritten && !mChanOp) ? writeRegIp : readFrom(1);
  endfunction

  // predicted successor, updates the model latches
  function automatic smStateT modelNext(smStateT s);
    smStateT n;
    case (s)
      waitForStart: begin
        mCondDone  = 1'b0;
        mIpWritten = 1'b0;
        mChanOp    = 1'b0;
        n = startBegin;
      end
      startBegin:         n = readMemSize1;
      readMemSize1:       n = afterMemSizeRead;
      afterMemSizeRead:   n = startReadCmd;
      startReadCmd:       n = startReadCmdP;
      startReadCmdP: begin
        mChanOp = (command[31:28] == `SM_OP_CHN);
        n = preexecute;
      end
      preexecute:         n = (mIp && !mChanOp) ? writeRegIp : readFrom(0);
      writeRegIp:         n = mChanOp ? writePrep : readFrom(0);
      readCond, fillCond: n = pC ? readCondP : afterCond();
      readCondP:          n = afterCond();
      readSrc1, fillSrc1: n = pS1 ? readSrc1P : readFrom(2);
      readSrc1P:          n = readFrom(2);
      readSrc0, fillSrc0: n = pS0 ? readSrc0P : readFrom(3);
      readSrc0P:          n = readFrom(3);
      readDst, fillDstP:  n = aluBegin;
      aluBegin:           n = chanWaitNextTime ? finishBegin : aluResults;
      aluResults:         n = mChanOp ? writeRegIp : writePrep;
      writePrep:          n = writeFrom(0);
      writeDstP:          n = isWb(fD) ? writeDst : writeFrom(1);
      writeDst:           n = writeFrom(1);
      writeCond:          n = writeFrom(2);
      writeSrc1:          n = writeFrom(3);
      writeSrc0:          n = finishBegin;
      finishBegin:        n = finishEnd;
      default:            n = waitForStart;
    endcase
    if (n == writeRegIp) begin
      mIpWritten = 1'b1;
    end
    if (s == readCond || s == fillCond) begin
      mCondDone = 1'b1;
    end
    return n;
  endfunction

  // steps until the FSM is idle again
  task automatic syncToStart();
    int steps;
    steps = 0;
    while (state != waitForStart) begin
      @(posedge next_state);
      #2;
      steps++;
      if (steps > 64) begin
        $display("timeout: sequencer never returned to waitForStart");
        stopRun();
      end
    end
  endtask

  // one instruction from waitForStart back to waitForStart, every step checked
  task automatic runInstruction(string name, logic [31:0] cmd, logic [31:0] cnd,
                                logic chanWait, logic cRd, logic s1Rd, logic s0Rd);
    smStateT expState;
    logic    prevDn;
    int      steps;
    command          = cmd;
    cond             = cnd;
    chanWaitNextTime = chanWait;
    isCndRead        = cRd;
    isS1Read         = s1Rd;
    isS0Read         = s0Rd;
    decodeModel();
    visited = '0;
    trace.delete();
    steps = 0;
    compareState({name, " start"}, waitForStart, state);
    do begin
      expState = modelNext(state);
      prevDn   = nextStateDn;
      @(posedge next_state);
      #2;
      compareState(name, expState, state);
      compareFlag({name, " ack toggle"}, ~prevDn, nextStateDn);
      visited[state] = 1'b1;
      trace.push_back(state);
      steps++;
      if (steps > 64) begin
        $display("timeout: %s did not finish within 64 steps", name);
        stopRun();
      end
    end while (state != waitForStart);
  endtask

  task automatic expectVisit(string name, smStateT s, logic exp);
    compareFlag({name, " visits ", s.name()}, exp, visited[s]);
  endtask

  task automatic checkDecodeRandom();
    for (int i = 0; i < 200; i++) begin
      @(posedge next_state);
      #2;
      command = randomBits(32);
      // zero cond about half the time
      cond = lfsrBit() ? randomBits(32) : '0;
      #20;
      decodeModel();
      compareFlag("decodeRandom ip", mIp, isIpSaveAllowed);
      compareFlag("decodeRandom d", mD, isDSaveAllowed);
      compareFlag("decodeRandom dptr", mDP, isDSavePtrAllowed);
      compareFlag("decodeRandom cnd", mC, isCndSaveAllowed);
      compareFlag("decodeRandom s1", mS1, isS1SaveAllowed);
      compareFlag("decodeRandom s0", mS0, isS0SaveAllowed);
    end
    // back on the drive point after a strobe edge
    @(posedge next_state);
    #2;
  endtask

  // all operands unused, unconditional
  task automatic checkIdleTrace();
    smStateT expSeq[13];
    expSeq = '{startBegin, readMemSize1, afterMemSizeRead, startReadCmd, startReadCmdP,
               preexecute, writeRegIp, aluBegin, aluResults, writePrep,
               finishBegin, finishEnd, waitForStart};
    runInstruction("idleTrace", {4'd0, 8'hFF, 4'b0000, 16'h0000}, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    if (trace.size() != 13) begin
      $display("idleTrace took %0d steps instead of 13", trace.size());
      stopRun();
    end
    for (int i = 0; i < 13; i++) begin
      compareState("idleTrace", expSeq[i], trace[i]);
    end
  endtask

  initial begin
    rst              = 1'b1;
    command          = '0;
    cond             = '0;
    chanWaitNextTime = 1'b0;
    isCndRead        = 1'b0;
    isS1Read         = 1'b0;
    isS0Read         = 1'b0;
    lfsrState        = 32'd17;
    mCondDone        = 1'b0;
    mIpWritten       = 1'b0;
    mChanOp          = 1'b0;
    visited          = '0;
    repeat (8) @(posedge next_state);
    #2;
    rst = 1'b0;
    compareState("reset", waitForStart, state);
    compareFlag("reset ack", 1'b0, nextStateDn);

    checkDecodeRandom();
    syncToStart();
    checkIdleTrace();

    // field order: op, flags C D S0 S1, ptr C D S0 S1, regs C D S0 S1
    runInstruction("fillOrder", {4'd0, 8'h00, 4'b0001, 16'h30F3}, 32'd5, 1'b0, 1'b1, 1'b0, 1'b0);
    expectVisit("fillOrder", readCond, 1'b1);
    expectVisit("fillOrder", fillSrc1, 1'b1);
    expectVisit("fillOrder", readSrc1P, 1'b1);
    expectVisit("fillOrder", fillSrc0, 1'b1);
    runInstruction("readOrder", {4'd0, 8'h00, 4'b0001, 16'h30F3}, 32'd5, 1'b0, 1'b0, 1'b0, 1'b0);
    expectVisit("readOrder", readSrc1, 1'b1);
    expectVisit("readOrder", fillSrc1, 1'b0);
    runInstruction("condFalse", {4'd0, 8'h03, 4'b1100, 16'h1660}, '0, 1'b0, 1'b0, 1'b0, 1'b1);
    expectVisit("condFalse", readCondP, 1'b1);
    expectVisit("condFalse", fillDstP, 1'b1);
    expectVisit("condFalse", writeDst, 1'b0);

    runInstruction("chanOp", {4'd12, 8'hFC, 4'b0000, 16'h0002}, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    expectVisit("chanOp", readSrc1, 1'b1);
    expectVisit("chanOp", aluResults, 1'b1);
    expectVisit("chanOp", writeRegIp, 1'b1);
    runInstruction("chanWait", {4'd12, 8'hFC, 4'b0000, 16'h0002}, '0, 1'b1, 1'b0, 1'b0, 1'b0);
    expectVisit("chanWait", aluResults, 1'b0);
    expectVisit("chanWait", writeRegIp, 1'b0);

    // D, cond and src0 saved, src1 shadowed by D
    runInstruction("writeBack", {4'd0, 8'h99, 4'b0100, 16'h5464}, 32'd1, 1'b0, 1'b0, 1'b0, 1'b0);
    expectVisit("writeBack", writeDstP, 1'b1);
    expectVisit("writeBack", writeDst, 1'b1);
    expectVisit("writeBack", writeCond, 1'b1);
    expectVisit("writeBack", writeSrc1, 1'b0);
    expectVisit("writeBack", writeSrc0, 1'b1);
    runInstruction("ptrStore", {4'd0, 8'hFF, 4'b0100, 16'h0000}, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    expectVisit("ptrStore", writeDstP, 1'b1);
    expectVisit("ptrStore", writeDst, 1'b0);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/stateManager.sv
`timescale 1ns/1ps
`default_nettype none

`include "stateManager_consts.svh"

module stateManager (
  input  wire logic                      next_state,
  input  wire logic                      rst,
  input  wire logic [`SM_CMD_WIDTH-1:0]  command,
  input  wire logic [`SM_DATA_WIDTH-1:0] cond,
  input  wire logic                      chanWaitNextTime,
  input  wire logic                      isCndRead,
  input  wire logic                      isS1Read,
  input  wire logic                      isS0Read,
  output stateManagerPkg::smStateT       state,
  output logic                           nextStateDn,
  output logic                           isIpSaveAllowed,
  output logic                           isDSaveAllowed,
  output logic                           isDSavePtrAllowed,
  output logic                           isCndSaveAllowed,
  output logic                           isS1SaveAllowed,
  output logic                           isS0SaveAllowed
);
  import stateManagerPkg::*;

  // decoded command
  regNumT   numS1;
  regNumT   numS0;
  regNumT   numD;
  regNumT   numCnd;
  regFlagsT flagsS1;
  regFlagsT flagsS0;
  regFlagsT flagsD;
  regFlagsT flagsCnd;
  logic     ptrS1;
  logic     ptrS0;
  logic     ptrD;
  logic     ptrCnd;
  cmdOpT    op;
  logic     condMet;
  // per-instruction latches
  logic     condDone;
  logic     ipWritten;
  logic     chanOp;
  // planner proposals
  smStateT  readNext;
  smStateT  writeNext;

  commandDecode commandDecode_i (
    .command, .cond,
    .numS1, .numS0, .numD, .numCnd,
    .flagsS1, .flagsS0, .flagsD, .flagsCnd,
    .ptrS1, .ptrS0, .ptrD, .ptrCnd,
    .op, .condMet,
    .isIpSaveAllowed, .isDSaveAllowed, .isDSavePtrAllowed,
    .isCndSaveAllowed, .isS1SaveAllowed, .isS0SaveAllowed
  );

  operandReadPlanner operandReadPlanner_i (
    .state,
    .numS1, .numS0, .numD, .numCnd,
    .flagsS1, .flagsS0, .flagsCnd,
    .ptrS1, .ptrS0, .ptrD, .ptrCnd,
    .isCndRead, .isS1Read, .isS0Read,
    .condMet, .isIpSaveAllowed,
    .condDone, .ipWritten, .chanOp,
    .readNext
  );

  writebackPlanner writebackPlanner_i (
    .state, .flagsD, .ptrD,
    .isDSaveAllowed, .isDSavePtrAllowed,
    .isCndSaveAllowed, .isS1SaveAllowed, .isS0SaveAllowed,
    .writeNext
  );

  stepSequencer stepSequencer_i (
    .next_state, .rst, .op,
    .isIpSaveAllowed, .chanWaitNextTime,
    .readNext, .writeNext,
    .state, .nextStateDn,
    .condDone, .ipWritten, .chanOp
  );

endmodule

`default_nettype wire

// File: rtl/stepSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module stepSequencer (
  input  wire logic                     next_state,
  input  wire logic                     rst,
  input  wire stateManagerPkg::cmdOpT   op,
  input  wire logic                     isIpSaveAllowed,
  input  wire logic                     chanWaitNextTime,
  input  wire stateManagerPkg::smStateT readNext,
  input  wire stateManagerPkg::smStateT writeNext,
  output stateManagerPkg::smStateT      state,
  output logic                          nextStateDn,
  output logic                          condDone,
  output logic                          ipWritten,
  output logic                          chanOp
);
  import stateManagerPkg::*;

  // one transition per strobe edge
  always_ff @(posedge next_state or posedge rst) begin
    if (rst) begin
      state       <= waitForStart;
      nextStateDn <= 1'b0;
      condDone    <= 1'b0;
      ipWritten   <= 1'b0;
      chanOp      <= 1'b0;
    end else begin
      // ack toggles on every step
      nextStateDn <= ~nextStateDn;
      case (state)
        waitForStart: begin
          // fresh instruction
          condDone  <= 1'b0;
          ipWritten <= 1'b0;
          chanOp    <= 1'b0;
          state     <= startBegin;
        end
        startBegin:       state <= readMemSize1;
        readMemSize1:     state <= afterMemSizeRead;
        afterMemSizeRead: state <= startReadCmd;
        startReadCmd:     state <= startReadCmdP;
        startReadCmdP: begin
          // command word is valid here
          chanOp <= (op == opChn);
          state  <= preexecute;
        end
        preexecute: begin
          if (isIpSaveAllowed && !chanOp) begin
            state     <= writeRegIp;
            ipWritten <= 1'b1;
          end else begin
            state <= readNext;
          end
        end
        writeRegIp: state <= chanOp ? writePrep : readNext;
        readCond, fillCond, readCondP,
        readSrc1, fillSrc1, readSrc1P,
        readSrc0, fillSrc0, readSrc0P,
        readDst, fillDstP: begin
          if (state == readCond || state == fillCond) begin
            condDone <= 1'b1;
          end
          // cond failed, IP update taken from the read chain
          if (readNext == writeRegIp) begin
            ipWritten <= 1'b1;
          end
          state <= readNext;
        end
        aluBegin: state <= chanWaitNextTime ? finishBegin : aluResults;
        aluResults: begin
          if (chanOp) begin
            // channel op updates IP after the transfer
            state     <= writeRegIp;
            ipWritten <= 1'b1;
          end else begin
            state <= writePrep;
          end
        end
        writePrep, writeDst, writeDstP,
        writeCond, writeSrc1, writeSrc0: state <= writeNext;
        finishBegin: state <= finishEnd;
        finishEnd:   state <= waitForStart;
        default:     state <= waitForStart;
      endcase
    end
  end

  // planners must only ever hand over encoded states
  assert property (@(posedge next_state) disable iff (rst) state <= finishEnd)
    else $error("state register left the legal range");

  // datapath counts on one ack edge per strobe
  assert property (@(posedge next_state) disable iff (rst)
                   !$past(rst) |-> nextStateDn != $past(nextStateDn))
    else $error("nextStateDn missed a toggle");

endmodule

`default_nettype wire

// File: rtl/writebackPlanner.sv
`timescale 1ns/1ps
`default_nettype none

module writebackPlanner (
  input  wire stateManagerPkg::smStateT   state,
  input  wire stateManagerPkg::regFlagsT  flagsD,
  input  wire logic                       ptrD,
  input  wire logic                       isDSaveAllowed,
  input  wire logic                       isDSavePtrAllowed,
  input  wire logic                       isCndSaveAllowed,
  input  wire logic                       isS1SaveAllowed,
  input  wire logic                       isS0SaveAllowed,
  output stateManagerPkg::smStateT        writeNext
);
  import stateManagerPkg::*;

  // remaining tail of the save order
  smStateT fromS0;
  smStateT fromS1;
  smStateT fromCnd;
  smStateT fromD;

  assign fromS0  = isS0SaveAllowed ? writeSrc0 : finishBegin;
  assign fromS1  = isS1SaveAllowed ? writeSrc1 : fromS0;
  assign fromCnd = isCndSaveAllowed ? writeCond : fromS1;

  // D through pointer first, register write after it
  always_comb begin
    if (isDSaveAllowed) begin
      fromD = ptrD ? writeDstP : writeDst;
    end else if (isDSavePtrAllowed) begin
      fromD = writeDstP;
    end else begin
      fromD = fromCnd;
    end
  end

  always_comb begin
    case (state)
      writePrep: writeNext = fromD;
      // pointer store may be followed by the register copy
      writeDstP: writeNext = (^flagsD) ? writeDst : fromCnd;
      writeDst:  writeNext = fromCnd;
      writeCond: writeNext = fromS1;
      writeSrc1: writeNext = fromS0;
      default:   writeNext = finishBegin;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/operandReadPlanner.sv
`timescale 1ns/1ps
`default_nettype none

`include "stateManager_consts.svh"

module operandReadPlanner (
  input  wire stateManagerPkg::smStateT   state,
  input  wire stateManagerPkg::regNumT    numS1,
  input  wire stateManagerPkg::regNumT    numS0,
  input  wire stateManagerPkg::regNumT    numD,
  input  wire stateManagerPkg::regNumT    numCnd,
  input  wire stateManagerPkg::regFlagsT  flagsS1,
  input  wire stateManagerPkg::regFlagsT  flagsS0,
  input  wire stateManagerPkg::regFlagsT  flagsCnd,
  input  wire logic                       ptrS1,
  input  wire logic                       ptrS0,
  input  wire logic                       ptrD,
  input  wire logic                       ptrCnd,
  input  wire logic                       isCndRead,
  input  wire logic                       isS1Read,
  input  wire logic                       isS0Read,
  input  wire logic                       condMet,
  input  wire logic                       isIpSaveAllowed,
  input  wire logic                       condDone,
  input  wire logic                       ipWritten,
  input  wire logic                       chanOp,
  output stateManagerPkg::smStateT        readNext
);
  import stateManagerPkg::*;

  logic cndUsed;
  logic s1Used;
  logic s0Used;
  // fill instead of read
  logic fillC;
  logic fillS1;
  logic fillS0;
  logic fillD;
  // next step when entering the chain at a given slot
  smStateT fromD;
  smStateT fromS0;
  smStateT fromS1;
  smStateT fromCnd;
  smStateT afterCond;

  assign cndUsed = ~(&flagsCnd);
  assign s1Used  = ~(&flagsS1);
  assign s0Used  = ~(&flagsS0);

  // IP comes from its counter, repeats come from the read latch
  assign fillC  = (numCnd == `SM_REG_IP);
  assign fillS1 = (numS1 == `SM_REG_IP)
               || (cndUsed && numS1 == numCnd && isCndRead);
  assign fillS0 = (numS0 == `SM_REG_IP)
               || (cndUsed && numS0 == numCnd && isCndRead)
               || (s1Used && numS0 == numS1 && isS1Read);
  assign fillD  = (numD == `SM_REG_IP)
               || (cndUsed && numD == numCnd && isCndRead)
               || (s1Used && numD == numS1 && isS1Read)
               || (s0Used && numD == numS0 && isS0Read);

  // dst only fetched when it is a pointer
  assign fromD   = ptrD ? (fillD ? fillDstP : readDst) : aluBegin;
  assign fromS0  = s0Used ? (fillS0 ? fillSrc0 : readSrc0) : fromD;
  assign fromS1  = s1Used ? (fillS1 ? fillSrc1 : readSrc1) : fromS0;
  assign fromCnd = (cndUsed && !condDone) ? (fillC ? fillCond : readCond) : fromS1;

  // failed condition skips straight to the IP update
  assign afterCond = (isIpSaveAllowed && !condMet && !ipWritten && !chanOp)
                   ? writeRegIp : fromS1;

  always_comb begin
    case (state)
      readCond, fillCond: readNext = ptrCnd ? readCondP : afterCond;
      readCondP:          readNext = afterCond;
      readSrc1, fillSrc1: readNext = ptrS1 ? readSrc1P : fromS0;
      readSrc1P:          readNext = fromS0;
      readSrc0, fillSrc0: readNext = ptrS0 ? readSrc0P : fromD;
      readSrc0P:          readNext = fromD;
      readDst, fillDstP:  readNext = aluBegin;
      // preexecute and writeRegIp start at the top
      default:            readNext = fromCnd;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/commandDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "stateManager_consts.svh"

module commandDecode (
  input  wire logic [`SM_CMD_WIDTH-1:0]  command,
  input  wire logic [`SM_DATA_WIDTH-1:0] cond,
  output stateManagerPkg::regNumT        numS1,
  output stateManagerPkg::regNumT        numS0,
  output stateManagerPkg::regNumT        numD,
  output stateManagerPkg::regNumT        numCnd,
  output stateManagerPkg::regFlagsT      flagsS1,
  output stateManagerPkg::regFlagsT      flagsS0,
  output stateManagerPkg::regFlagsT      flagsD,
  output stateManagerPkg::regFlagsT      flagsCnd,
  output logic                           ptrS1,
  output logic                           ptrS0,
  output logic                           ptrD,
  output logic                           ptrCnd,
  output stateManagerPkg::cmdOpT         op,
  output logic                           condMet,
  output logic                           isIpSaveAllowed,
  output logic                           isDSaveAllowed,
  output logic                           isDSavePtrAllowed,
  output logic                           isCndSaveAllowed,
  output logic                           isS1SaveAllowed,
  output logic                           isS0SaveAllowed
);
  import stateManagerPkg::*;

  logic [3:0] opField;
  // operand written back, exactly one flag bit set
  logic wbCnd;
  logic wbS1;
  logic wbS0;

  // field split
  assign numS1    = command[`SM_S1_NUM];
  assign numS0    = command[`SM_S0_NUM];
  assign numD     = command[`SM_D_NUM];
  assign numCnd   = command[`SM_CND_NUM];
  assign ptrS1    = command[`SM_S1_PTR];
  assign ptrS0    = command[`SM_S0_PTR];
  assign ptrD     = command[`SM_D_PTR];
  assign ptrCnd   = command[`SM_CND_PTR];
  assign flagsS1  = command[`SM_S1_FLAGS];
  assign flagsS0  = command[`SM_S0_FLAGS];
  assign flagsD   = command[`SM_D_FLAGS];
  assign flagsCnd = command[`SM_CND_FLAGS];
  assign opField  = command[`SM_OP_FIELD];

  // fold unknown codes onto the ALU member
  assign op = (opField == `SM_OP_CHN) ? opChn : opAlu;

  // unconditional, or cond read and nonzero
  assign condMet = (&flagsCnd) || (|cond);

  assign wbCnd = ^flagsCnd;
  assign wbS1  = ^flagsS1;
  assign wbS0  = ^flagsS0;

  // register write of D vs store through D pointer
  assign isDSaveAllowed    = ~(&flagsD) && condMet;
  assign isDSavePtrAllowed = (&flagsD) && ptrD && condMet;

  // priority D, cond, src1, src0 on a shared register
  assign isCndSaveAllowed = wbCnd && !(isDSaveAllowed && numD == numCnd);
  assign isS1SaveAllowed  = wbS1
                         && !(isDSaveAllowed && numD == numS1)
                         && !(isCndSaveAllowed && numCnd == numS1);
  assign isS0SaveAllowed  = wbS0
                         && !(isDSaveAllowed && numD == numS0)
                         && !(isCndSaveAllowed && numCnd == numS0)
                         && !(isS1SaveAllowed && numS1 == numS0);

  // IP gets its own increment only if nothing else lands on it
  assign isIpSaveAllowed = !((isDSaveAllowed && numD == `SM_REG_IP)
                          || (wbCnd && numCnd == `SM_REG_IP)
                          || (wbS1 && numS1 == `SM_REG_IP)
                          || (wbS0 && numS0 == `SM_REG_IP));

  // a D slot either writes a register or stores through its pointer
  always_comb begin
    assert ($onehot0({isDSaveAllowed, isDSavePtrAllowed}))
      else $error("D register and D pointer save both allowed");
  end

endmodule

`default_nettype wire

// File: rtl/stateManagerPkg.sv
`default_nettype none

`include "stateManager_consts.svh"

package stateManagerPkg;

  // register number of one operand slot
  typedef logic [3:0] regNumT;

  // 2'b11 means unused, unconditional for cond
  // one bit set means read and written back
  typedef logic [1:0] regFlagsT;

  // anything that is not a channel op runs as a plain ALU op
  typedef enum logic [3:0] {
    opAlu = 4'd0,
    opChn = `SM_OP_CHN
  } cmdOpT;

  // sequencer states, encoded in this order
  typedef enum logic [4:0] {
    waitForStart,
    startBegin,
    readMemSize1,
    afterMemSizeRead,
    startReadCmd,
    startReadCmdP,
    preexecute,
    writeRegIp,
    readCond,
    fillCond,
    readCondP,
    readSrc1,
    fillSrc1,
    readSrc1P,
    readSrc0,
    fillSrc0,
    readSrc0P,
    readDst,
    fillDstP,
    aluBegin,
    aluResults,
    writePrep,
    writeDst,
    writeDstP,
    writeCond,
    writeSrc1,
    writeSrc0,
    finishBegin,
    finishEnd
  } smStateT;

endpackage

`default_nettype wire

// File: rtl/stateManager_consts.svh
`ifndef STATE_MANAGER_CONSTS_SVH
`define STATE_MANAGER_CONSTS_SVH

// datapath and command word widths
`define SM_DATA_WIDTH 32
`define SM_CMD_WIDTH 32

// register number of the instruction pointer
`define SM_REG_IP 4'd15

// opcode of the channel operation
`define SM_OP_CHN 4'd12

// register number fields
`define SM_S1_NUM 3:0
`define SM_S0_NUM 7:4
`define SM_D_NUM 11:8
`define SM_CND_NUM 15:12

// pointer bits, same slot order
`define SM_S1_PTR 16
`define SM_S0_PTR 17
`define SM_D_PTR 18
`define SM_CND_PTR 19

// flag pairs
`define SM_S1_FLAGS 21:20
`define SM_S0_FLAGS 23:22
`define SM_D_FLAGS 25:24
`define SM_CND_FLAGS 27:26

// opcode field
`define SM_OP_FIELD 31:28

`endif
